/* bench/tb_pong_i2c_link.sv */
`default_nettype none

module tb_pong_i2c_link;

    localparam logic [7:0] addr_byte = 8'haa;
    localparam int quarter_clocks = 4;
    localparam int random_frames = 4;
    // random frames plus retrigger, abort and recovery frames
    localparam int total_frames = random_frames + 3;
    // start, four bytes of nine bits and stop, four quarters each, plus handoffs
    localparam int frame_clocks = 4 * 38 * quarter_clocks + 20;
    localparam int gap_clocks = 40;
    localparam int watchdog_clocks = total_frames * (frame_clocks + gap_clocks) + 500;

    logic       clk;
    logic       reset;
    logic       ball_send_trigger;
    logic [9:0] ball_y;
    logic [7:0] ball_vy;
    logic       is_ball_moving_left;
    logic       sda_in;
    logic       scl;
    logic       sda_drive_low;
    logic       is_transfer;
    logic [7:0] intf_led;

    // bus decoder state
    logic [7:0] rx_bytes [$];
    logic [7:0] rx_shift;
    logic       prev_scl;
    logic       prev_sda;
    int         rx_bits = 0;
    int         start_count = 0;
    int         stop_count = 0;
    event       frame_end;

    // what the current frame should carry
    logic [9:0] exp_y;
    logic [7:0] exp_vy;
    logic       expect_abort;
    int         frames_checked = 0;
    logic [15:0] lfsr_state = 16'd29210;

    // pull-up only, the slave never acknowledges
    assign sda_in = ~sda_drive_low;

    pong_i2c_link pong_i2c_link_i (
        .clk                 (clk),
        .reset               (reset),
        .ball_send_trigger   (ball_send_trigger),
        .ball_y              (ball_y),
        .ball_vy             (ball_vy),
        .is_ball_moving_left (is_ball_moving_left),
        .sda_in              (sda_in),
        .scl                 (scl),
        .sda_drive_low       (sda_drive_low),
        .is_transfer         (is_transfer),
        .intf_led            (intf_led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
        if (actual !== want) begin
            stop_with_failure($sformatf("error at time %0t: %s = 0x%0h, expected 0x%0h",
                                        $time, name, actual, want));
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_bits(input int count, output logic [15:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // address, y high bits padded with zeros, y low byte, vertical speed
    function automatic logic [31:0] expected_frame(input logic [9:0] y, input logic [7:0] vy);
        expected_frame = {addr_byte, y[9:8], 6'b00_0000, y[7:0], vy};
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic send_trigger(input logic [9:0] y, input logic [7:0] vy);
        ball_y = y;
        ball_vy = vy;
        ball_send_trigger = 1'b1;
        next_cycle;
        ball_send_trigger = 1'b0;
    endtask

    // START, STOP and bits sampled away from the DUT's clock edge
    always @(negedge clk) begin
        if (reset) begin
            prev_scl = 1'b1;
            prev_sda = 1'b1;
            rx_bits = 0;
        end else begin
            if (prev_scl && scl && prev_sda && !sda_in) begin
                start_count++;
                rx_bits = 0;
            end else if (prev_scl && scl && !prev_sda && sda_in) begin
                stop_count++;
                rx_bits = 0;
                -> frame_end;
            end else if (!prev_scl && scl) begin
                if (rx_bits < 8) begin
                    rx_shift = {rx_shift[6:0], sda_in};
                end
                rx_bits++;
                if (rx_bits == 8) begin
                    rx_bytes.push_back(rx_shift);
                end else if (rx_bits == 9) begin
                    rx_bits = 0;
                end
            end
            prev_scl = scl;
            prev_sda = sda_in;
        end
    end

    always @(negedge clk) begin
        if (!reset && !(intf_led inside {8'h00, 8'h01, 8'h04, 8'h08, 8'h10})) begin
            stop_with_failure($sformatf("intf_led showed 0x%02h, which is no state code",
                                        intf_led));
        end
    end

    initial begin : compare_frames
        logic [31:0] want;
        int i;
        forever begin
            @(frame_end);
            if (expect_abort) begin
                if (rx_bytes.size() >= 4) begin
                    stop_with_failure("aborted frame still delivered all four bytes");
                end
                if (rx_bytes.size() > 0) begin
                    check_value("rx_byte[0]", rx_bytes[0], addr_byte);
                end
            end else begin
                want = expected_frame(exp_y, exp_vy);
                check_value("rx_byte_count", rx_bytes.size(), 4);
                for (i = 0; i < 4; i++) begin
                    check_value($sformatf("rx_byte[%0d]", i), rx_bytes[i],
                                want[31 - 8 * i -: 8]);
                end
                // sequencer sits in its stop state while the STOP goes out
                check_value("intf_led", intf_led, 8'h08);
                check_value("is_transfer", is_transfer, 1);
            end
            rx_bytes.delete();
            frames_checked++;
        end
    end

    // retrigger_at of zero means no second trigger during the frame
    task automatic run_frame(input logic [9:0] y, input logic [7:0] vy, input int retrigger_at);
        int starts_before;
        int stops_before;
        int cycles;
        starts_before = start_count;
        stops_before = stop_count;
        exp_y = y;
        exp_vy = vy;
        expect_abort = 1'b0;
        send_trigger(y, vy);
        check_value("is_transfer", is_transfer, 1);
        cycles = 0;
        while (is_transfer) begin
            if (retrigger_at != 0 && cycles == retrigger_at) begin
                ball_y = ~y;
                ball_vy = ~vy;
                ball_send_trigger = 1'b1;
            end else begin
                ball_send_trigger = 1'b0;
            end
            next_cycle;
            cycles++;
        end
        ball_send_trigger = 1'b0;
        check_value("start_count", start_count, starts_before + 1);
        check_value("stop_count", stop_count, stops_before + 1);
        repeat (gap_clocks) next_cycle;
    endtask

    task automatic abort_frame(input logic [9:0] y, input logic [7:0] vy, input int abort_at);
        int starts_before;
        int stops_before;
        starts_before = start_count;
        stops_before = stop_count;
        expect_abort = 1'b1;
        send_trigger(y, vy);
        repeat (abort_at) next_cycle;
        check_value("is_transfer", is_transfer, 1);
        is_ball_moving_left = 1'b1;
        next_cycle;
        check_value("is_transfer", is_transfer, 0);
        while (stop_count == stops_before) begin
            next_cycle;
        end
        repeat (gap_clocks) next_cycle;
        check_value("scl", scl, 1);
        check_value("sda_drive_low", sda_drive_low, 0);
        check_value("start_count", start_count, starts_before + 1);
        is_ball_moving_left = 1'b0;
        expect_abort = 1'b0;
        next_cycle;
    endtask

    initial begin : stimulus
        logic [15:0] y_bits;
        logic [15:0] vy_bits;
        int n;
        reset = 1'b1;
        ball_send_trigger = 1'b0;
        ball_y = '0;
        ball_vy = '0;
        is_ball_moving_left = 1'b0;
        expect_abort = 1'b0;
        exp_y = '0;
        exp_vy = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle;
        check_value("scl", scl, 1);
        check_value("sda_drive_low", sda_drive_low, 0);
        check_value("is_transfer", is_transfer, 0);
        check_value("intf_led", intf_led, 0);

        for (n = 0; n < random_frames; n++) begin
            random_bits(10, y_bits);
            random_bits(8, vy_bits);
            run_frame(y_bits[9:0], vy_bits[7:0], 0);
        end

        // second trigger lands in the middle of the data bytes
        random_bits(10, y_bits);
        random_bits(8, vy_bits);
        run_frame(y_bits[9:0], vy_bits[7:0], 300);

        // ball turns left during the second byte
        random_bits(10, y_bits);
        random_bits(8, vy_bits);
        abort_frame(y_bits[9:0], vy_bits[7:0], 200);

        random_bits(10, y_bits);
        random_bits(8, vy_bits);
        run_frame(y_bits[9:0], vy_bits[7:0], 0);

        check_value("frames_checked", frames_checked, total_frames);
        $display("All checks passed");
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_clocks) @(posedge clk);
        stop_with_failure("watchdog expired before the test sequence finished");
    end

endmodule

`default_nettype wire

/* logic/ball_frame_sequencer.sv */
`default_nettype none

module ball_frame_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ball_send_trigger,
    input  i2c_link_pkg::ball_pos_t   ball_y,
    input  i2c_link_pkg::ball_speed_t ball_vy,
    input  logic                      is_ball_moving_left,
    input  logic                      ready,
    input  logic                      tx_done,
    output logic                      start,
    output logic                      stop,
    output logic                      i2c_en,
    output i2c_link_pkg::i2c_byte_t   tx_data,
    output logic                      is_transfer,
    output i2c_link_pkg::led_t        intf_led
);

    import i2c_link_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    // bytes completed on the bus, address included
    logic [2:0] byte_cnt;
    logic [2:0] byte_cnt_next;
    logic       capture;

    // ball state frozen at the trigger
    i2c_byte_t y_hi_byte;
    i2c_byte_t y_lo_byte;
    i2c_byte_t vy_byte;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= idle;
            byte_cnt <= '0;
        end else begin
            state    <= state_next;
            byte_cnt <= byte_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            y_hi_byte <= {ball_y[9:8], 6'b00_0000};
            y_lo_byte <= ball_y[7:0];
            vy_byte   <= ball_vy;
        end
    end

    // next byte to offer, picked by how many are already out
    always_comb begin
        case (byte_cnt)
            3'd1:    tx_data = y_hi_byte;
            3'd2:    tx_data = y_lo_byte;
            3'd3:    tx_data = vy_byte;
            default: tx_data = slave_addr;
        endcase
    end

    always_comb begin
        state_next    = state;
        byte_cnt_next = byte_cnt;
        capture       = 1'b0;
        start         = 1'b0;
        stop          = 1'b0;
        i2c_en        = 1'b0;
        is_transfer   = 1'b1;
        intf_led      = 8'h00;

        if (tx_done) begin
            byte_cnt_next = byte_cnt + 3'd1;
        end

        case (state)
            idle: begin
                is_transfer = 1'b0;
                // master must be fully free, so a trigger during an abort stop is dropped
                if (ball_send_trigger && ready) begin
                    start         = 1'b1;
                    i2c_en        = 1'b1;
                    capture       = 1'b1;
                    byte_cnt_next = '0;
                    state_next    = start_wait;
                end
            end

            start_wait: begin
                start  = 1'b1;
                i2c_en = 1'b1;
                if (!ready) begin
                    state_next = wait_ready;
                end
            end

            wait_ready: begin
                intf_led = 8'h01;
                // held high while the master is busy, a drop means abandon
                i2c_en   = 1'b1;
                stop     = (byte_cnt == 3'd4);
                if (ready) begin
                    if (byte_cnt == 3'd4) begin
                        state_next = i2c_link_pkg::stop;
                    end else begin
                        state_next = send_data;
                    end
                end
            end

            send_data: begin
                intf_led = 8'h04;
                i2c_en   = 1'b1;
                if (!ready) begin
                    state_next = wait_ready;
                end
            end

            i2c_link_pkg::stop: begin
                intf_led = 8'h08;
                // STOP already accepted, wait until it is on the bus
                if (ready) begin
                    state_next = done;
                end
            end

            done: begin
                intf_led    = 8'h10;
                is_transfer = 1'b0;
                state_next  = idle;
            end

            default: begin
                state_next = idle;
            end
        endcase

        // ball heading away, give up the frame
        if (is_ball_moving_left) begin
            state_next = idle;
            start      = 1'b0;
            stop       = 1'b0;
            i2c_en     = 1'b0;
            capture    = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/i2c_byte_master.sv */
`default_nettype none

module i2c_byte_master (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i2c_en,
    input  logic                    start,
    input  logic                    stop,
    input  i2c_link_pkg::i2c_byte_t tx_data,
    input  logic                    sda_in,
    output logic                    ready,
    output logic                    tx_done,
    output logic                    scl,
    output logic                    sda_drive_low
);

    import i2c_link_pkg::*;

    typedef logic [$clog2(quarter_bit_clocks)-1:0] quarter_cnt_t;

    typedef enum logic [1:0] {
        ph_idle,
        ph_start,
        ph_bit,
        ph_stop
    } phase_t;

    phase_t       phase;
    phase_t       phase_next;
    quarter_cnt_t q_cnt;
    quarter_cnt_t q_cnt_next;
    logic [1:0]   quarter;
    logic [1:0]   quarter_next;
    // 0..7 data, 8 is the acknowledge clock
    logic [3:0]   bit_idx;
    logic [3:0]   bit_next;
    logic         ready_next;
    // between START and STOP
    logic         bus_open;
    logic         open_next;
    logic         load;
    logic         step;
    logic         bit_end;
    logic         scl_level;
    logic         sda_low_level;

    i2c_byte_t shift_q;
    logic      sda_sample;

    assign step    = (phase != ph_idle) && (q_cnt == quarter_cnt_t'(quarter_bit_clocks - 1));
    assign bit_end = step && (quarter == 2'd3);

    always_comb begin
        phase_next   = phase;
        q_cnt_next   = q_cnt;
        quarter_next = quarter;
        bit_next     = bit_idx;
        ready_next   = ready;
        open_next    = bus_open;
        load         = 1'b0;
        tx_done      = 1'b0;

        if (phase != ph_idle) begin
            if (step) begin
                q_cnt_next   = '0;
                quarter_next = quarter + 2'd1;
            end else begin
                q_cnt_next = q_cnt + 1'b1;
            end
        end

        case (phase)
            ph_idle: begin
                if (i2c_en) begin
                    ready_next   = 1'b0;
                    q_cnt_next   = '0;
                    quarter_next = 2'd0;
                    if (start) begin
                        phase_next = ph_start;
                        open_next  = 1'b1;
                    end else if (stop) begin
                        phase_next = ph_stop;
                    end else begin
                        phase_next = ph_bit;
                        bit_next   = '0;
                        load       = 1'b1;
                    end
                end else if (bus_open) begin
                    // frame dropped between commands
                    ready_next   = 1'b0;
                    q_cnt_next   = '0;
                    quarter_next = 2'd0;
                    phase_next   = ph_stop;
                end
            end

            ph_start: begin
                if (bit_end) begin
                    if (i2c_en) begin
                        phase_next = ph_idle;
                        ready_next = 1'b1;
                    end else begin
                        phase_next = ph_stop;
                    end
                end
            end

            ph_bit: begin
                if (bit_end) begin
                    if (!i2c_en) begin
                        // finish this bit only, then close the frame
                        phase_next = ph_stop;
                    end else if (bit_idx == 4'd8) begin
                        phase_next = ph_idle;
                        ready_next = 1'b1;
                        tx_done    = 1'b1;
                    end else begin
                        bit_next = bit_idx + 4'd1;
                    end
                end
            end

            ph_stop: begin
                if (bit_end) begin
                    phase_next = ph_idle;
                    ready_next = 1'b1;
                    open_next  = 1'b0;
                end
            end

            default: begin
                phase_next = ph_idle;
            end
        endcase
    end

    // bus levels per quarter, idle holds whatever the last command left
    always_comb begin
        scl_level     = scl;
        sda_low_level = sda_drive_low;
        case (phase)
            ph_start: begin
                // SDA falls in q1 with SCL still high
                scl_level     = (quarter != 2'd3);
                sda_low_level = (quarter != 2'd0);
            end
            ph_bit: begin
                scl_level     = (quarter == 2'd1) || (quarter == 2'd2);
                sda_low_level = (bit_idx != 4'd8) && !shift_q[7];
            end
            ph_stop: begin
                // SDA rises in q2 with SCL high
                scl_level     = (quarter != 2'd0);
                sda_low_level = (quarter == 2'd0) || (quarter == 2'd1);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase         <= ph_idle;
            q_cnt         <= '0;
            quarter       <= 2'd0;
            bit_idx       <= '0;
            ready         <= 1'b1;
            bus_open      <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else begin
            phase         <= phase_next;
            q_cnt         <= q_cnt_next;
            quarter       <= quarter_next;
            bit_idx       <= bit_next;
            ready         <= ready_next;
            bus_open      <= open_next;
            scl           <= scl_level;
            sda_drive_low <= sda_low_level;
        end
    end

    // bus level shifts in behind the outgoing bits, ack lands there too
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_data;
        end else if (bit_end && (phase == ph_bit)) begin
            shift_q <= {shift_q[6:0], sda_sample};
        end
    end

    // sampled at the end of the SCL high time
    always_ff @(posedge clk) begin
        if (step && (quarter == 2'd2) && (phase == ph_bit)) begin
            sda_sample <= sda_in;
        end
    end

endmodule

`default_nettype wire

/* logic/i2c_link_pkg.sv */
`default_nettype none

package i2c_link_pkg;

    // one byte on the bus
    typedef logic [7:0] i2c_byte_t;

    // ball vertical coordinate from the game
    typedef logic [9:0] ball_pos_t;

    // ball vertical speed
    typedef logic [7:0] ball_speed_t;

    // one-hot status display
    typedef logic [7:0] led_t;

    // peer board address, write bit included
    localparam i2c_byte_t slave_addr = 8'haa;

    // clk cycles per quarter of an SCL period
    localparam int unsigned quarter_bit_clocks = 4;

    // frame sequencer states
    typedef enum logic [2:0] {
        idle,
        start_wait,
        wait_ready,
        send_data,
        stop,
        done
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/pong_i2c_link.sv */
`default_nettype none

module pong_i2c_link (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ball_send_trigger,
    input  i2c_link_pkg::ball_pos_t   ball_y,
    input  i2c_link_pkg::ball_speed_t ball_vy,
    input  logic                      is_ball_moving_left,
    input  logic                      sda_in,
    output logic                      scl,
    output logic                      sda_drive_low,
    output logic                      is_transfer,
    output i2c_link_pkg::led_t        intf_led
);

    import i2c_link_pkg::*;

    // command path into the byte master
    logic      cmd_start;
    logic      cmd_stop;
    logic      cmd_en;
    i2c_byte_t cmd_data;

    // status back from the byte master
    logic      master_ready;
    logic      master_tx_done;

    ball_frame_sequencer ball_frame_sequencer_i (
        .clk                 (clk),
        .reset               (reset),
        .ball_send_trigger   (ball_send_trigger),
        .ball_y              (ball_y),
        .ball_vy             (ball_vy),
        .is_ball_moving_left (is_ball_moving_left),
        .ready               (master_ready),
        .tx_done             (master_tx_done),
        .start               (cmd_start),
        .stop                (cmd_stop),
        .i2c_en              (cmd_en),
        .tx_data             (cmd_data),
        .is_transfer         (is_transfer),
        .intf_led            (intf_led)
    );

    i2c_byte_master i2c_byte_master_i (
        .clk           (clk),
        .reset         (reset),
        .i2c_en        (cmd_en),
        .start         (cmd_start),
        .stop          (cmd_stop),
        .tx_data       (cmd_data),
        .sda_in        (sda_in),
        .ready         (master_ready),
        .tx_done       (master_tx_done),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f tb.f \
        --top-module tb_pong_i2c_link -Mdir obj_dir -o sim \
    && ./obj_dir/sim \
    || { echo "simulation failed" >&2; exit 1; }

/* tb.f */
logic/i2c_link_pkg.sv
logic/ball_frame_sequencer.sv
logic/i2c_byte_master.sv
logic/pong_i2c_link.sv
bench/tb_pong_i2c_link.sv
